// File: src.f
+incdir+hdl
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_branch_unit.sv
hdl/exe_agu.sv
hdl/exe_sequencer.sv
hdl/exe_stage.sv
test/exe_stage_tb.sv

// File: Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - hdl

sources:
  - hdl/exe_pkg.sv
  - hdl/exe_alu.sv
  - hdl/exe_branch_unit.sv
  - hdl/exe_agu.sv
  - hdl/exe_sequencer.sv
  - hdl/exe_stage.sv
  - target: test
    files:
      - test/exe_stage_tb.sv

// File: test/exe_stage_tb.sv
// Testbench for the execute stage
// Random stimulus, reference model and concurrent output checks
`include "exe_config.svh"

module exe_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ALU_COUNT    = 200;
  localparam int BR_OPS       = 12;
  localparam int BR_REPEAT    = 20;
  localparam int CALL_REPEAT  = 20;
  localparam int MEM_REPEAT   = 30;
  localparam int FLUSH_REPEAT = 50;
  localparam int STIM_CYCLES  = 5 + 15 * ALU_COUNT + BR_OPS * BR_REPEAT * 3 + CALL_REPEAT * 4
                              + 6 * MEM_REPEAT + FLUSH_REPEAT * 5 + 4;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

  logic                      clk_i;
  logic                      rst_i;
  logic                      flush_i;
  exe_pkg::opcode_e          op_i;
  exe_pkg::pcb_t             pcb_i;
  logic [`EXE_XLEN-1:0]      reg_a_i;
  logic [`EXE_XLEN-1:0]      reg_b_i;
  logic [`EXE_REG_IDX_W-1:0] wr_idx0_i;
  logic [`EXE_REG_IDX_W-1:0] wr_idx1_i;
  logic [`EXE_XLEN-1:0]      operand_i;
  logic [`EXE_IMM_W-1:0]     imm_i;
  logic [`EXE_XLEN-1:0]      sp_i;
  logic [`EXE_XLEN-1:0]      fp_i;
  logic [`EXE_XLEN-1:0]      pc_i;
  exe_pkg::pcb_t             pcb_o;
  logic [`EXE_REG_IDX_W-1:0] wr_idx0_o;
  logic [`EXE_REG_IDX_W-1:0] wr_idx1_o;
  logic [`EXE_XLEN-1:0]      result0_o;
  logic [`EXE_XLEN-1:0]      result1_o;
  logic [`EXE_XLEN-1:0]      mem_addr_o;
  logic [`EXE_XLEN-1:0]      mem_data_o;
  logic [`EXE_XLEN-1:0]      pc_o;
  logic                      branch_flag_o;
  logic [`EXE_XLEN-1:0]      branch_target_o;
  logic                      flush_o;

  // Reference model state and expected outputs
  exe_pkg::pcb_t             exp_pcb;
  logic                      exp_flag;
  logic [`EXE_XLEN-1:0]      exp_target;
  logic [`EXE_XLEN-1:0]      exp_res0;
  logic [`EXE_XLEN-1:0]      exp_res1;
  logic [`EXE_XLEN-1:0]      exp_addr;
  logic [`EXE_XLEN-1:0]      exp_data;
  logic [`EXE_XLEN-1:0]      exp_pc;
  logic [`EXE_REG_IDX_W-1:0] exp_idx0;
  logic [`EXE_REG_IDX_W-1:0] exp_idx1;
  logic                      chk_res0;
  logic                      chk_res1;
  logic                      chk_addr;
  logic                      chk_data;
  logic                      chk_pc;
  logic                      m_call_second;
  logic [`EXE_XLEN-1:0]      m_call_target;
  logic [`EXE_XLEN-1:0]      m_cmp_a;
  logic [`EXE_XLEN-1:0]      m_cmp_b;

  logic [31:0] rng_state = 32'hc88c_2acb;
  int unsigned cycle_cnt = 0;

  exe_pkg::opcode_e alu_ops [15] = '{
    exe_pkg::OP_ADD, exe_pkg::OP_SUB, exe_pkg::OP_AND, exe_pkg::OP_OR, exe_pkg::OP_XOR,
    exe_pkg::OP_ASHL, exe_pkg::OP_ASHR, exe_pkg::OP_LSHR, exe_pkg::OP_MUL, exe_pkg::OP_NEG,
    exe_pkg::OP_NOT, exe_pkg::OP_MOV, exe_pkg::OP_INC, exe_pkg::OP_DEC, exe_pkg::OP_LDI
  };
  exe_pkg::opcode_e br_ops [BR_OPS] = '{
    exe_pkg::OP_BEQ, exe_pkg::OP_BNE, exe_pkg::OP_BLT, exe_pkg::OP_BGT, exe_pkg::OP_BLTU,
    exe_pkg::OP_BGTU, exe_pkg::OP_BGE, exe_pkg::OP_BLE, exe_pkg::OP_BGEU, exe_pkg::OP_BLEU,
    exe_pkg::OP_JMP, exe_pkg::OP_JMPA
  };
  exe_pkg::opcode_e mem_ops [6] = '{
    exe_pkg::OP_LD, exe_pkg::OP_LDA, exe_pkg::OP_LDO, exe_pkg::OP_STA, exe_pkg::OP_PUSH,
    exe_pkg::OP_POP
  };
  // Control bits as decode would send them for each memory op
  logic [3:0] mem_pcb [6] = '{4'b1010, 4'b1010, 4'b1010, 4'b0001, 4'b1001, 4'b1110};

  exe_stage exe_stage_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected));
  endtask

  function automatic logic is_alu_op(input exe_pkg::opcode_e op);
    logic found;
    found = 1'b0;
    foreach (alu_ops[k])
      if (alu_ops[k] == op)
        found = 1'b1;
    return found;
  endfunction

  function automatic logic [31:0] alu_ref(input exe_pkg::opcode_e op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] operand,
                                          input logic [9:0] imm);
    case (op)
      exe_pkg::OP_ADD:  return a + b;
      exe_pkg::OP_SUB:  return a - b;
      exe_pkg::OP_AND:  return a & b;
      exe_pkg::OP_OR:   return a | b;
      exe_pkg::OP_XOR:  return a ^ b;
      exe_pkg::OP_ASHL: return a << b[4:0];
      exe_pkg::OP_ASHR: return $signed(a) >>> b[4:0];
      exe_pkg::OP_LSHR: return a >> b[4:0];
      exe_pkg::OP_MUL:  return a * b;
      exe_pkg::OP_NEG:  return 32'd0 - b;
      exe_pkg::OP_NOT:  return ~b;
      exe_pkg::OP_MOV:  return b;
      exe_pkg::OP_INC:  return a + {24'd0, imm[7:0]};
      exe_pkg::OP_DEC:  return a - {24'd0, imm[7:0]};
      default:          return operand;
    endcase
  endfunction

  // Relation between the operands of the last CMP, jumps always taken
  function automatic logic relation_holds(input exe_pkg::opcode_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      exe_pkg::OP_BEQ:  return a == b;
      exe_pkg::OP_BNE:  return a != b;
      exe_pkg::OP_BLT:  return $signed(a) < $signed(b);
      exe_pkg::OP_BGT:  return $signed(a) > $signed(b);
      exe_pkg::OP_BLTU: return a < b;
      exe_pkg::OP_BGTU: return a > b;
      exe_pkg::OP_BGE:  return $signed(a) >= $signed(b);
      exe_pkg::OP_BLE:  return $signed(a) <= $signed(b);
      exe_pkg::OP_BGEU: return a >= b;
      exe_pkg::OP_BLEU: return a <= b;
      exe_pkg::OP_JMP:  return 1'b1;
      exe_pkg::OP_JMPA: return 1'b1;
      default:          return 1'b0;
    endcase
  endfunction

  always @(posedge clk_i)
  begin : ref_model
    logic        squash;
    logic        call_start;
    logic        redirect;
    logic [31:0] pcrel;
    if (rst_i)
    begin
      m_call_second <= 1'b0;
      exp_pcb       <= 4'b0000;
      exp_flag      <= 1'b0;
      chk_res0      <= 1'b0;
      chk_res1      <= 1'b0;
      chk_addr      <= 1'b0;
      chk_data      <= 1'b0;
      chk_pc        <= 1'b0;
    end
    else
    begin
      squash     = exp_flag | flush_i;
      call_start = !m_call_second && (op_i == exe_pkg::OP_JSR || op_i == exe_pkg::OP_JSRA);
      redirect   = !squash && (m_call_second || relation_holds(op_i, m_cmp_a, m_cmp_b));
      pcrel      = pc_i + 32'd2 + 32'($signed(imm_i)) * 32'd2;
      exp_flag      <= redirect;
      m_call_second <= !squash && call_start;
      exp_pcb       <= squash ? 4'b0000 : (call_start || m_call_second) ? 4'b1001 : pcb_i;
      if (op_i == exe_pkg::OP_JMP)
        exp_target <= reg_a_i;
      else if (op_i == exe_pkg::OP_JMPA)
        exp_target <= operand_i;
      else
        exp_target <= pcrel;
      if (m_call_second)
        exp_target <= m_call_target;
      chk_res0 <= 1'b0;
      chk_res1 <= 1'b0;
      chk_addr <= 1'b0;
      chk_data <= 1'b0;
      // Stage pc follows every instruction that is not squashed
      chk_pc   <= !squash;
      exp_pc   <= pc_i;
      if (!squash && !m_call_second && op_i == exe_pkg::OP_CMP)
      begin
        m_cmp_a <= reg_a_i;
        m_cmp_b <= reg_b_i;
      end
      if (!squash && m_call_second)
      begin
        // Frame pointer push at sp-4
        {chk_res0, chk_addr, chk_data} <= 3'b111;
        exp_res0 <= sp_i - 32'd4;
        exp_idx0 <= `EXE_REG_IDX_W'(`EXE_SP_INDEX);
        exp_addr <= sp_i - 32'd4;
        exp_data <= fp_i;
      end
      else if (!squash && call_start)
      begin
        {chk_res0, chk_addr, chk_data} <= 3'b111;
        exp_res0      <= sp_i - 32'd8;
        exp_idx0      <= `EXE_REG_IDX_W'(`EXE_SP_INDEX);
        exp_addr      <= sp_i - 32'd8;
        exp_data      <= pc_i + ((op_i == exe_pkg::OP_JSRA) ? 32'd6 : 32'd2);
        m_call_target <= (op_i == exe_pkg::OP_JSR) ? reg_a_i : operand_i;
      end
      else if (!squash)
      begin
        case (op_i)
          exe_pkg::OP_LD:
          begin
            chk_addr <= 1'b1;
            exp_addr <= reg_b_i;
          end
          exe_pkg::OP_LDA:
          begin
            chk_addr <= 1'b1;
            exp_addr <= operand_i;
          end
          exe_pkg::OP_LDO:
          begin
            chk_addr <= 1'b1;
            exp_addr <= operand_i + reg_b_i;
          end
          exe_pkg::OP_STA:
          begin
            {chk_addr, chk_data} <= 2'b11;
            exp_addr <= operand_i;
            exp_data <= reg_a_i;
          end
          exe_pkg::OP_PUSH:
          begin
            {chk_res0, chk_addr, chk_data} <= 3'b111;
            exp_res0 <= reg_a_i - 32'd4;
            exp_idx0 <= wr_idx0_i;
            exp_addr <= reg_a_i - 32'd4;
            exp_data <= reg_b_i;
          end
          exe_pkg::OP_POP:
          begin
            {chk_res1, chk_addr} <= 2'b11;
            exp_res1 <= reg_a_i + 32'd4;
            exp_idx1 <= wr_idx1_i;
            exp_addr <= reg_a_i;
          end
          default:
          begin
            chk_res0 <= is_alu_op(op_i);
            exp_res0 <= alu_ref(op_i, reg_a_i, reg_b_i, operand_i, imm_i);
            exp_idx0 <= wr_idx0_i;
          end
        endcase
      end
    end
  end

  ast_reset: assert property (@(posedge clk_i)
    (rst_i && cycle_cnt != 0) |-> (pcb_o == 4'b0000 && !branch_flag_o && !flush_o))
    else fail_run("Stage outputs are not cleared while reset is held");
  ast_pcb: assert property (@(posedge clk_i) disable iff (rst_i) pcb_o == exp_pcb)
    else report_mismatch("pcb_o", 32'($sampled(pcb_o)), 32'($sampled(exp_pcb)));
  ast_flag: assert property (@(posedge clk_i) disable iff (rst_i) branch_flag_o == exp_flag)
    else report_mismatch("branch_flag_o", 32'($sampled(branch_flag_o)),
                         32'($sampled(exp_flag)));
  ast_flush: assert property (@(posedge clk_i) disable iff (rst_i) flush_o == exp_flag)
    else report_mismatch("flush_o", 32'($sampled(flush_o)), 32'($sampled(exp_flag)));
  ast_target: assert property (@(posedge clk_i) disable iff (rst_i)
    exp_flag |-> branch_target_o == exp_target)
    else report_mismatch("branch_target_o", $sampled(branch_target_o), $sampled(exp_target));
  ast_res0: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_res0 |-> result0_o == exp_res0)
    else report_mismatch("result0_o", $sampled(result0_o), $sampled(exp_res0));
  ast_idx0: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_res0 |-> wr_idx0_o == exp_idx0)
    else report_mismatch("wr_idx0_o", 32'($sampled(wr_idx0_o)), 32'($sampled(exp_idx0)));
  ast_res1: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_res1 |-> result1_o == exp_res1)
    else report_mismatch("result1_o", $sampled(result1_o), $sampled(exp_res1));
  ast_idx1: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_res1 |-> wr_idx1_o == exp_idx1)
    else report_mismatch("wr_idx1_o", 32'($sampled(wr_idx1_o)), 32'($sampled(exp_idx1)));
  ast_addr: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_addr |-> mem_addr_o == exp_addr)
    else report_mismatch("mem_addr_o", $sampled(mem_addr_o), $sampled(exp_addr));
  ast_data: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_data |-> mem_data_o == exp_data)
    else report_mismatch("mem_data_o", $sampled(mem_data_o), $sampled(exp_data));
  ast_pc: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_pc |-> pc_o == exp_pc)
    else report_mismatch("pc_o", $sampled(pc_o), $sampled(exp_pc));

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // One instruction per cycle with random operands
  task automatic drive_op(input exe_pkg::opcode_e op, input logic [3:0] pcb,
                          input logic flush);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] frame;
    a = rand32();
    b = rand32();
    r = rand32();
    frame = rand32();
    // Equal operands now and then so that eq branches are taken
    if (r[2:0] == 3'd0)
      b = a;
    @(posedge clk_i);
    op_i      <= op;
    pcb_i     <= pcb;
    flush_i   <= flush;
    reg_a_i   <= a;
    reg_b_i   <= b;
    operand_i <= rand32();
    imm_i     <= r[17:8];
    wr_idx0_i <= r[23:20];
    wr_idx1_i <= r[27:24];
    pc_i      <= rand32() & 32'hffff_fffe;
    // Frame registers change only with a new call
    if (op == exe_pkg::OP_JSR || op == exe_pkg::OP_JSRA)
    begin
      sp_i <= frame & 32'hffff_fffc;
      fp_i <= rand32();
    end
  endtask

  initial
  begin : stimulus
    rst_i     = 1'b1;
    flush_i   = 1'b0;
    op_i      = exe_pkg::OP_NOP;
    pcb_i     = 4'b0000;
    reg_a_i   = '0;
    reg_b_i   = '0;
    wr_idx0_i = '0;
    wr_idx1_i = '0;
    operand_i = '0;
    imm_i     = '0;
    sp_i      = 32'h0000_1000;
    fp_i      = '0;
    pc_i      = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (alu_ops[k])
      for (int i = 0; i < ALU_COUNT; i++)
        drive_op(alu_ops[k], 4'b1000, 1'b0);
    // CMP, branch, then an instruction that a taken branch squashes
    foreach (br_ops[k])
      for (int i = 0; i < BR_REPEAT; i++)
      begin
        drive_op(exe_pkg::OP_CMP, 4'b0000, 1'b0);
        drive_op(br_ops[k], 4'b0000, 1'b0);
        drive_op(exe_pkg::OP_ADD, 4'b1000, 1'b0);
      end
    for (int i = 0; i < CALL_REPEAT; i++)
    begin
      drive_op(i[0] ? exe_pkg::OP_JSRA : exe_pkg::OP_JSR, 4'b1001, 1'b0);
      drive_op(exe_pkg::OP_ADD, 4'b1000, 1'b0);
      drive_op(exe_pkg::OP_SUB, 4'b1000, 1'b0);
      drive_op(exe_pkg::OP_NOP, 4'b0000, 1'b0);
    end
    foreach (mem_ops[k])
      for (int i = 0; i < MEM_REPEAT; i++)
        drive_op(mem_ops[k], mem_pcb[k], 1'b0);
    // Flushed ALU op and flushed CMP between a CMP and its branch
    for (int i = 0; i < FLUSH_REPEAT; i++)
    begin
      drive_op(exe_pkg::OP_CMP, 4'b0000, 1'b0);
      drive_op(alu_ops[i % 15], 4'b1000, 1'b1);
      drive_op(exe_pkg::OP_CMP, 4'b0000, 1'b1);
      drive_op(br_ops[i % BR_OPS], 4'b0000, 1'b0);
      drive_op(exe_pkg::OP_NOP, 4'b0000, 1'b0);
    end
    repeat (3) drive_op(exe_pkg::OP_NOP, 4'b0000, 1'b0);
    @(posedge clk_i);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: hdl/exe_stage.sv
// Execute stage top level
// Sequencer with ALU, branch unit and address generator
`include "exe_config.svh"

module exe_stage (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  exe_pkg::opcode_e           op_i,
  input  exe_pkg::pcb_t              pcb_i,
  input  logic [`EXE_XLEN-1:0]      reg_a_i,
  input  logic [`EXE_XLEN-1:0]      reg_b_i,
  input  logic [`EXE_REG_IDX_W-1:0] wr_idx0_i,
  input  logic [`EXE_REG_IDX_W-1:0] wr_idx1_i,
  input  logic [`EXE_XLEN-1:0]      operand_i,
  input  logic [`EXE_IMM_W-1:0]     imm_i,
  input  logic [`EXE_XLEN-1:0]      sp_i,
  input  logic [`EXE_XLEN-1:0]      fp_i,
  input  logic [`EXE_XLEN-1:0]      pc_i,
  output exe_pkg::pcb_t              pcb_o,
  output logic [`EXE_REG_IDX_W-1:0] wr_idx0_o,
  output logic [`EXE_REG_IDX_W-1:0] wr_idx1_o,
  output logic [`EXE_XLEN-1:0]      result0_o,
  output logic [`EXE_XLEN-1:0]      result1_o,
  output logic [`EXE_XLEN-1:0]      mem_addr_o,
  output logic [`EXE_XLEN-1:0]      mem_data_o,
  output logic [`EXE_XLEN-1:0]      pc_o,
  output logic                      branch_flag_o,
  output logic [`EXE_XLEN-1:0]      branch_target_o,
  output logic                      flush_o
);

  logic [`EXE_XLEN-1:0] alu_result;
  logic                 branch_taken;
  logic [`EXE_XLEN-1:0] branch_target;
  logic [`EXE_XLEN-1:0] mem_addr;
  logic [`EXE_XLEN-1:0] mem_data;
  logic [`EXE_XLEN-1:0] ptr_result;
  logic                 cc_load;
  logic                 call_second;

  exe_alu exe_alu_i (
    .op_i      (op_i),
    .reg_a_i   (reg_a_i),
    .reg_b_i   (reg_b_i),
    .operand_i (operand_i),
    .imm_i     (imm_i),
    .result_o  (alu_result)
  );

  exe_branch_unit exe_branch_unit_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .op_i      (op_i),
    .reg_a_i   (reg_a_i),
    .reg_b_i   (reg_b_i),
    .imm_i     (imm_i),
    .pc_i      (pc_i),
    .operand_i (operand_i),
    .cc_load_i (cc_load),
    .taken_o   (branch_taken),
    .target_o  (branch_target)
  );

  exe_agu exe_agu_i (
    .op_i          (op_i),
    .reg_a_i       (reg_a_i),
    .reg_b_i       (reg_b_i),
    .operand_i     (operand_i),
    .sp_i          (sp_i),
    .fp_i          (fp_i),
    .pc_i          (pc_i),
    .call_second_i (call_second),
    .addr_o        (mem_addr),
    .data_o        (mem_data),
    .ptr_o         (ptr_result)
  );

  exe_sequencer exe_sequencer_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .op_i            (op_i),
    .pcb_i           (pcb_i),
    .wr_idx0_i       (wr_idx0_i),
    .wr_idx1_i       (wr_idx1_i),
    .pc_i            (pc_i),
    .alu_result_i    (alu_result),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .mem_addr_i      (mem_addr),
    .mem_data_i      (mem_data),
    .ptr_result_i    (ptr_result),
    .cc_load_o       (cc_load),
    .call_second_o   (call_second),
    .pcb_o           (pcb_o),
    .wr_idx0_o       (wr_idx0_o),
    .wr_idx1_o       (wr_idx1_o),
    .result0_o       (result0_o),
    .result1_o       (result1_o),
    .mem_addr_o      (mem_addr_o),
    .mem_data_o      (mem_data_o),
    .pc_o            (pc_o),
    .branch_flag_o   (branch_flag_o),
    .branch_target_o (branch_target_o),
    .flush_o         (flush_o)
  );

endmodule

// File: hdl/exe_sequencer.sv
// Call state machine, squash and flush logic
// Output registers of the execute stage
`include "exe_config.svh"

module exe_sequencer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  exe_pkg::opcode_e           op_i,
  input  exe_pkg::pcb_t              pcb_i,
  input  logic [`EXE_REG_IDX_W-1:0] wr_idx0_i,
  input  logic [`EXE_REG_IDX_W-1:0] wr_idx1_i,
  input  logic [`EXE_XLEN-1:0]      pc_i,
  input  logic [`EXE_XLEN-1:0]      alu_result_i,
  input  logic                      branch_taken_i,
  input  logic [`EXE_XLEN-1:0]      branch_target_i,
  input  logic [`EXE_XLEN-1:0]      mem_addr_i,
  input  logic [`EXE_XLEN-1:0]      mem_data_i,
  input  logic [`EXE_XLEN-1:0]      ptr_result_i,
  output logic                      cc_load_o,
  output logic                      call_second_o,
  output exe_pkg::pcb_t              pcb_o,
  output logic [`EXE_REG_IDX_W-1:0] wr_idx0_o,
  output logic [`EXE_REG_IDX_W-1:0] wr_idx1_o,
  output logic [`EXE_XLEN-1:0]      result0_o,
  output logic [`EXE_XLEN-1:0]      result1_o,
  output logic [`EXE_XLEN-1:0]      mem_addr_o,
  output logic [`EXE_XLEN-1:0]      mem_data_o,
  output logic [`EXE_XLEN-1:0]      pc_o,
  output logic                      branch_flag_o,
  output logic [`EXE_XLEN-1:0]      branch_target_o,
  output logic                      flush_o
);

  logic          call_second_q;
  logic          squash;
  logic          call_start;
  logic          call_cycle;
  logic          redirect;
  exe_pkg::pcb_t pcb_next;

  // Drop the incoming instruction after our own redirect or on downstream flush
  assign squash     = branch_flag_o | flush_i;
  assign call_start = !call_second_q && (op_i == exe_pkg::OP_JSR || op_i == exe_pkg::OP_JSRA);
  assign call_cycle = call_start | call_second_q;
  // Second call cycle jumps; the op presented then is ignored
  assign redirect   = !squash && (call_second_q || branch_taken_i);

  assign cc_load_o     = !squash && !call_second_q && op_i == exe_pkg::OP_CMP;
  assign call_second_o = call_second_q;

  always_comb
  begin
    if (call_cycle)
      pcb_next = '{wb_a: 1'b1, wb_b: 1'b0, mem_rd: 1'b0, mem_wr: 1'b1};
    else
      pcb_next = pcb_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      call_second_q <= 1'b0;
      pcb_o         <= {`EXE_PCB_W{1'b0}};
      branch_flag_o <= 1'b0;
      flush_o       <= 1'b0;
    end
    else
    begin
      call_second_q <= !squash && call_start;
      pcb_o         <= squash ? {`EXE_PCB_W{1'b0}} : pcb_next;
      branch_flag_o <= redirect;
      flush_o       <= redirect;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!squash)
    begin
      pc_o       <= pc_i;
      mem_addr_o <= mem_addr_i;
      mem_data_o <= mem_data_i;
      // Pointer update of POP
      result1_o  <= ptr_result_i;
      wr_idx1_o  <= wr_idx1_i;
      if (call_cycle)
      begin
        result0_o <= ptr_result_i;
        wr_idx0_o <= `EXE_REG_IDX_W'(`EXE_SP_INDEX);
      end
      else if (op_i == exe_pkg::OP_PUSH)
      begin
        result0_o <= ptr_result_i;
        wr_idx0_o <= wr_idx0_i;
      end
      else
      begin
        result0_o <= alu_result_i;
        wr_idx0_o <= wr_idx0_i;
      end
      // Call target is captured in cycle 1 and held for the jump
      if (!call_second_q)
        branch_target_o <= branch_target_i;
    end
  end

endmodule

// File: hdl/exe_agu.sv
// Memory address, store data and pointer update for loads, stores,
// push, pop and the two pushes of a call
`include "exe_config.svh"

module exe_agu (
  input  exe_pkg::opcode_e      op_i,
  input  logic [`EXE_XLEN-1:0] reg_a_i,
  input  logic [`EXE_XLEN-1:0] reg_b_i,
  input  logic [`EXE_XLEN-1:0] operand_i,
  input  logic [`EXE_XLEN-1:0] sp_i,
  input  logic [`EXE_XLEN-1:0] fp_i,
  input  logic [`EXE_XLEN-1:0] pc_i,
  input  logic                 call_second_i,
  output logic [`EXE_XLEN-1:0] addr_o,
  output logic [`EXE_XLEN-1:0] data_o,
  output logic [`EXE_XLEN-1:0] ptr_o
);

  logic [`EXE_XLEN-1:0] frame_lo;
  logic [`EXE_XLEN-1:0] frame_hi;

  // Return address goes below the saved frame pointer
  assign frame_lo = sp_i - `EXE_XLEN'(`EXE_FRAME_BYTES);
  assign frame_hi = sp_i - `EXE_XLEN'(`EXE_FRAME_BYTES / 2);

  always_comb
  begin
    addr_o = '0;
    data_o = '0;
    ptr_o  = '0;
    if (call_second_i)
    begin
      // Current op is ignored while the frame pointer is pushed
      addr_o = frame_hi;
      data_o = fp_i;
      ptr_o  = frame_hi;
    end
    else
    begin
      case (op_i)
        exe_pkg::OP_JSR,
        exe_pkg::OP_JSRA:
        begin
          addr_o = frame_lo;
          // JSRA carries a 32-bit address after the opcode
          data_o = pc_i + ((op_i == exe_pkg::OP_JSRA) ? `EXE_XLEN'(6) : `EXE_XLEN'(2));
          ptr_o  = frame_lo;
        end
        exe_pkg::OP_LD:
          addr_o = reg_b_i;
        exe_pkg::OP_LDA:
          addr_o = operand_i;
        exe_pkg::OP_LDO:
          addr_o = operand_i + reg_b_i;
        exe_pkg::OP_STA:
        begin
          addr_o = operand_i;
          data_o = reg_a_i;
        end
        exe_pkg::OP_PUSH:
        begin
          addr_o = reg_a_i - `EXE_XLEN'(4);
          data_o = reg_b_i;
          ptr_o  = reg_a_i - `EXE_XLEN'(4);
        end
        exe_pkg::OP_POP:
        begin
          addr_o = reg_a_i;
          ptr_o  = reg_a_i + `EXE_XLEN'(4);
        end
        default:
        begin
          addr_o = '0;
        end
      endcase
    end
  end

endmodule

// File: hdl/exe_branch_unit.sv
// Condition-code register, branch decision and branch target
`include "exe_config.svh"

module exe_branch_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  exe_pkg::opcode_e       op_i,
  input  logic [`EXE_XLEN-1:0]  reg_a_i,
  input  logic [`EXE_XLEN-1:0]  reg_b_i,
  input  logic [`EXE_IMM_W-1:0] imm_i,
  input  logic [`EXE_XLEN-1:0]  pc_i,
  input  logic [`EXE_XLEN-1:0]  operand_i,
  input  logic                  cc_load_i,
  output logic                  taken_o,
  output logic [`EXE_XLEN-1:0]  target_o
);

  exe_pkg::cc_t         cc_q;
  logic [`EXE_XLEN-1:0] pcrel_target;

  // Flags only change on a CMP that is not squashed
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cc_q <= '0;
    end
    else if (cc_load_i)
    begin
      cc_q.eq  <= reg_a_i == reg_b_i;
      cc_q.lt  <= $signed(reg_a_i) < $signed(reg_b_i);
      cc_q.gt  <= $signed(reg_a_i) > $signed(reg_b_i);
      cc_q.ltu <= reg_a_i < reg_b_i;
      cc_q.gtu <= reg_a_i > reg_b_i;
    end
  end

  // Halfword offset, sign extended, relative to the next instruction
  assign pcrel_target = pc_i + `EXE_XLEN'(2)
                      + {{(`EXE_XLEN-`EXE_IMM_W-1){imm_i[`EXE_IMM_W-1]}}, imm_i, 1'b0};

  always_comb
  begin
    case (op_i)
      exe_pkg::OP_BEQ:  taken_o = cc_q.eq;
      exe_pkg::OP_BNE:  taken_o = !cc_q.eq;
      exe_pkg::OP_BLT:  taken_o = cc_q.lt;
      exe_pkg::OP_BGT:  taken_o = cc_q.gt;
      exe_pkg::OP_BLTU: taken_o = cc_q.ltu;
      exe_pkg::OP_BGTU: taken_o = cc_q.gtu;
      exe_pkg::OP_BGE:  taken_o = cc_q.eq | cc_q.gt;
      exe_pkg::OP_BLE:  taken_o = cc_q.eq | cc_q.lt;
      exe_pkg::OP_BGEU: taken_o = cc_q.eq | cc_q.gtu;
      exe_pkg::OP_BLEU: taken_o = cc_q.eq | cc_q.ltu;
      exe_pkg::OP_JMP,
      exe_pkg::OP_JMPA: taken_o = 1'b1;
      default:          taken_o = 1'b0;
    endcase
  end

  always_comb
  begin
    case (op_i)
      exe_pkg::OP_JMP,
      exe_pkg::OP_JSR:  target_o = reg_a_i;
      exe_pkg::OP_JMPA,
      exe_pkg::OP_JSRA: target_o = operand_i;
      default:          target_o = pcrel_target;
    endcase
  end

endmodule

// File: hdl/exe_alu.sv
// Integer result unit for register-writing operations
`include "exe_config.svh"

module exe_alu (
  input  exe_pkg::opcode_e       op_i,
  input  logic [`EXE_XLEN-1:0]  reg_a_i,
  input  logic [`EXE_XLEN-1:0]  reg_b_i,
  input  logic [`EXE_XLEN-1:0]  operand_i,
  input  logic [`EXE_IMM_W-1:0] imm_i,
  output logic [`EXE_XLEN-1:0]  result_o
);

  logic [`EXE_XLEN-1:0] incdec;
  logic [4:0]           shamt;

  // Inc/dec amount is an unsigned byte
  assign incdec = {{(`EXE_XLEN-8){1'b0}}, imm_i[7:0]};
  assign shamt  = reg_b_i[4:0];

  always_comb
  begin
    case (op_i)
      exe_pkg::OP_ADD:
        result_o = reg_a_i + reg_b_i;
      exe_pkg::OP_SUB:
        result_o = reg_a_i - reg_b_i;
      exe_pkg::OP_AND:
        result_o = reg_a_i & reg_b_i;
      exe_pkg::OP_OR:
        result_o = reg_a_i | reg_b_i;
      exe_pkg::OP_XOR:
        result_o = reg_a_i ^ reg_b_i;
      exe_pkg::OP_ASHL:
        result_o = reg_a_i << shamt;
      exe_pkg::OP_ASHR:
        result_o = $signed(reg_a_i) >>> shamt;
      exe_pkg::OP_LSHR:
        result_o = reg_a_i >> shamt;
      // Low word of the product only
      exe_pkg::OP_MUL:
        result_o = reg_a_i * reg_b_i;
      exe_pkg::OP_NEG:
        result_o = -reg_b_i;
      exe_pkg::OP_NOT:
        result_o = ~reg_b_i;
      exe_pkg::OP_MOV:
        result_o = reg_b_i;
      exe_pkg::OP_INC:
        result_o = reg_a_i + incdec;
      exe_pkg::OP_DEC:
        result_o = reg_a_i - incdec;
      exe_pkg::OP_LDI:
        result_o = operand_i;
      default:
        result_o = '0;
    endcase
  end

endmodule

// File: hdl/exe_pkg.sv
// Shared types of the execute stage
// Opcode enumeration, condition flags and pipeline control bits
package exe_pkg;

  // Opcodes as delivered by decode
  typedef enum logic [5:0] {
    OP_NOP  = 6'h00,
    OP_LDI  = 6'h01,
    OP_MOV  = 6'h02,
    OP_JSRA = 6'h03,
    OP_ADD  = 6'h05,
    OP_PUSH = 6'h06,
    OP_POP  = 6'h07,
    OP_LDA  = 6'h08,
    OP_STA  = 6'h09,
    OP_LD   = 6'h0a,
    OP_LDO  = 6'h0c,
    OP_CMP  = 6'h0e,
    OP_JSR  = 6'h19,
    OP_JMPA = 6'h1a,
    OP_JMP  = 6'h25,
    OP_AND  = 6'h26,
    OP_LSHR = 6'h27,
    OP_ASHL = 6'h28,
    OP_SUB  = 6'h29,
    OP_NEG  = 6'h2a,
    OP_OR   = 6'h2b,
    OP_NOT  = 6'h2c,
    OP_ASHR = 6'h2d,
    OP_XOR  = 6'h2e,
    OP_MUL  = 6'h2f,
    OP_INC  = 6'h30,
    OP_DEC  = 6'h31,
    // Conditional branches
    OP_BEQ  = 6'h32,
    OP_BNE  = 6'h33,
    OP_BLT  = 6'h34,
    OP_BGT  = 6'h35,
    OP_BLTU = 6'h36,
    OP_BGTU = 6'h37,
    OP_BGE  = 6'h38,
    OP_BLE  = 6'h39,
    OP_BGEU = 6'h3a,
    OP_BLEU = 6'h3b
  } opcode_e;

  // Flags from the last CMP, lt/gt signed and ltu/gtu unsigned
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

  // All zero is a bubble
  typedef struct packed {
    logic wb_a;
    logic wb_b;
    logic mem_rd;
    logic mem_wr;
  } pcb_t;

endpackage

// File: hdl/exe_config.svh
// Width and layout macros for the execute stage
// Data width, control-bit width, register index and call-frame constants
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// Data and address width
`define EXE_XLEN 32

// Pipeline control bits: wb_a, wb_b, mem_rd, mem_wr
`define EXE_PCB_W 4

// Register file index width
`define EXE_REG_IDX_W 4

// Short instruction field, branch offset or inc/dec amount
`define EXE_IMM_W 10

// Register index of the stack pointer
`define EXE_SP_INDEX 1

// Bytes pushed by a call, return address then frame pointer
`define EXE_FRAME_BYTES 8

`endif
